// ==== common/dcache_defs.svh ====
`ifndef DCACHE_DEFS_SVH
`define DCACHE_DEFS_SVH

// cache geometry
`define DC_WAYS      4    // associativity
`define DC_SETS      8    // sets per way
`define DC_INDEX_W   3    // log2 of DC_SETS
`define DC_OFFSET_W  5    // byte offset inside a 32 byte line

// address split is tag | index | offset, 24 + 3 + 5 = 32
`define DC_TAG_W     24

// data path
`define DC_WORD_W    32   // cpu word and memory beat
`define DC_LINE_W    256  // eight words per line
`define DC_BEATS     8    // beats per memory burst, one line

// lru bookkeeping
`define DC_STAMP_W   16   // saturating use counter width

`endif

// ==== common/dcache_pkg.sv ====
`default_nettype none

`include "dcache_defs.svh"

package dcache_pkg;

  // controller states
  // miss path is WB_REQ/WB_DATA only for a dirty victim, then FILL_REQ/FILL_DATA
  typedef enum logic [2:0] {
    IDLE,       // waiting for a cpu request
    LOOKUP,     // tag compare on the registered request
    WB_REQ,     // write-back address phase
    WB_DATA,    // write-back data beats
    FILL_REQ,   // refill address phase
    FILL_DATA,  // refill data beats
    RESP        // read data held for the cpu
  } dc_state_e;

  typedef logic [`DC_TAG_W-1:0]        dc_tag_t;    // upper address bits
  typedef logic [`DC_INDEX_W-1:0]      dc_index_t;  // set select
  typedef logic [$clog2(`DC_WAYS)-1:0] dc_way_t;    // way number
  typedef logic [`DC_LINE_W-1:0]       dc_line_t;   // word 0 in the low bits

endpackage

`default_nettype wire

// ==== verilog/dcache_line_store.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "dcache_defs.svh"

module dcache_line_store
  import dcache_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  dc_index_t             index,
  input  dc_tag_t               tag,
  input  logic [2:0]            word_sel,
  input  logic [`DC_WORD_W-1:0] wdata,
  input  logic [3:0]            wstrb,
  input  logic                  hit_wr_en,
  input  logic                  fill_beat_en,
  input  logic [`DC_WORD_W-1:0] fill_data,
  input  dc_way_t               fill_way,
  output logic                  hit,
  output dc_way_t               hit_way,
  output dc_line_t              cur_line,
  output logic                  victim_dirty,
  output dc_tag_t               victim_tag
);

  logic     valid_q [`DC_WAYS][`DC_SETS];
  logic     dirty_q [`DC_WAYS][`DC_SETS];
  dc_tag_t  tag_q   [`DC_WAYS][`DC_SETS];
  dc_line_t data_q  [`DC_WAYS][`DC_SETS];

  logic [`DC_WAYS-1:0] way_hit;
  dc_line_t            merged_line;  // hit line with strobed bytes replaced

  always_comb begin
    for (int w = 0; w < `DC_WAYS; w++) begin
      way_hit[w] = valid_q[w][index] && (tag_q[w][index] == tag);
    end
  end

  assign hit = |way_hit;

  always_comb begin
    hit_way = '0;
    for (int w = `DC_WAYS - 1; w >= 0; w--) begin
      if (way_hit[w]) hit_way = dc_way_t'(w);
    end
  end

  // one read port, hit way wins, else the victim for write-back
  assign cur_line     = hit ? data_q[hit_way][index] : data_q[fill_way][index];
  assign victim_dirty = dirty_q[fill_way][index];
  assign victim_tag   = tag_q[fill_way][index];

  always_comb begin
    merged_line = cur_line;
    for (int b = 0; b < 4; b++) begin
      if (wstrb[b])
        merged_line[word_sel * `DC_WORD_W + b * 8 +: 8] = wdata[b * 8 +: 8];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int w = 0; w < `DC_WAYS; w++) begin
        for (int s = 0; s < `DC_SETS; s++) begin
          valid_q[w][s] <= 1'b0;
          dirty_q[w][s] <= 1'b0;
        end
      end
    end else if (hit_wr_en) begin
      dirty_q[hit_way][index] <= 1'b1;
    end else if (fill_beat_en) begin
      valid_q[fill_way][index] <= 1'b1;
      dirty_q[fill_way][index] <= 1'b0;  // fresh copy of memory
    end
  end

  always_ff @(posedge clk) begin
    if (hit_wr_en) begin
      data_q[hit_way][index] <= merged_line;
    end else if (fill_beat_en) begin
      // new beat enters at the top, after eight beats word 0 sits lowest
      data_q[fill_way][index] <= {fill_data, data_q[fill_way][index][`DC_LINE_W-1:`DC_WORD_W]};
      tag_q[fill_way][index]  <= tag;
    end
  end

  a_one_hit: assert property (@(posedge clk) disable iff (rst) $onehot0(way_hit));

endmodule

`default_nettype wire

// ==== verilog/lru_tracker.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "dcache_defs.svh"

module lru_tracker
  import dcache_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  dc_index_t index,
  input  logic      touch_en,
  input  dc_way_t   hit_way,
  output dc_way_t   victim_way
);

  logic [`DC_STAMP_W-1:0] stamp_cnt;                      // next use stamp
  logic [`DC_STAMP_W-1:0] stamp_q [`DC_WAYS][`DC_SETS];   // last use per way
  logic [`DC_STAMP_W-1:0] min_stamp;

  always_ff @(posedge clk) begin
    if (rst) begin
      stamp_cnt <= `DC_STAMP_W'(1);  // untouched ways keep 0 and go first
      for (int w = 0; w < `DC_WAYS; w++) begin
        for (int s = 0; s < `DC_SETS; s++) stamp_q[w][s] <= '0;
      end
    end else if (touch_en) begin
      stamp_q[hit_way][index] <= stamp_cnt;
      if (stamp_cnt != '1) stamp_cnt <= stamp_cnt + 1'b1;  // saturate
    end
  end

  // oldest stamp at this set, strict compare keeps the lowest way on a tie
  always_comb begin
    min_stamp  = stamp_q[0][index];
    victim_way = '0;
    for (int w = 1; w < `DC_WAYS; w++) begin
      if (stamp_q[w][index] < min_stamp) begin
        min_stamp  = stamp_q[w][index];
        victim_way = dc_way_t'(w);
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/dcache_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "dcache_defs.svh"

module dcache_ctrl
  import dcache_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  req_valid,
  input  logic                  req_write,
  input  logic [31:0]           req_addr,
  input  logic [31:0]           req_wdata,
  input  logic [3:0]            req_wstrb,
  output logic                  req_ready,
  output logic                  rsp_valid,
  output logic [31:0]           rsp_data,
  input  logic                  rsp_ready,
  output logic                  mem_rd_req_valid,
  output logic [31:0]           mem_rd_req_addr,
  input  logic                  mem_rd_req_ready,
  input  logic                  mem_rd_rsp_valid,
  input  logic [31:0]           mem_rd_rsp_data,
  input  logic                  mem_rd_rsp_last,
  output logic                  mem_rd_rsp_ready,
  output logic                  mem_wr_req_valid,
  output logic [31:0]           mem_wr_req_addr,
  input  logic                  mem_wr_req_ready,
  output logic                  mem_wr_data_valid,
  output logic [31:0]           mem_wr_data,
  output logic                  mem_wr_data_last,
  input  logic                  mem_wr_data_ready,
  input  logic                  hit,
  input  dc_way_t               hit_way,
  input  dc_line_t              cur_line,
  input  dc_way_t               victim_way,
  input  logic                  victim_dirty,
  input  dc_tag_t               victim_tag,
  output dc_index_t             index,
  output dc_tag_t               tag,
  output logic [2:0]            word_sel,
  output logic                  hit_wr_en,
  output logic                  fill_beat_en,
  output logic [`DC_WORD_W-1:0] fill_data,
  output logic [`DC_WORD_W-1:0] wdata,
  output logic [3:0]            wstrb,
  output logic                  touch_en
);

  dc_state_e             state, next_state;
  logic                  req_write_q;  // request register held until back in IDLE
  logic [31:0]           req_addr_q;
  logic [`DC_WORD_W-1:0] req_wdata_q;
  logic [3:0]            req_wstrb_q;
  logic [2:0]            wb_cnt;       // write-back beat number
  dc_line_t              wb_line;      // victim line shifted out word 0 first
  logic                  req_fire;

  assign req_fire = req_valid && req_ready;

  always_ff @(posedge clk) begin
    if (rst) state <= IDLE;
    else     state <= next_state;
  end

  // high only while in IDLE and low during reset
  always_ff @(posedge clk) begin
    if (rst) req_ready <= 1'b0;
    else     req_ready <= (next_state == IDLE);
  end

  always_ff @(posedge clk) begin
    if (req_fire) begin
      req_write_q <= req_write;
      req_addr_q  <= req_addr;
      req_wdata_q <= req_wdata;
      req_wstrb_q <= req_wstrb;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) wb_cnt <= '0;
    else if (state == WB_REQ) wb_cnt <= '0;
    else if (state == WB_DATA && mem_wr_data_ready) wb_cnt <= wb_cnt + 3'd1;
  end

  always_ff @(posedge clk) begin
    if (state == WB_REQ) wb_line <= cur_line;  // cur_line is the victim since nothing hits here
    else if (state == WB_DATA && mem_wr_data_ready) wb_line <= wb_line >> `DC_WORD_W;
  end

  always_comb begin
    next_state = state;
    case (state)
      IDLE:      if (req_fire) next_state = LOOKUP;
      LOOKUP: begin
        if (hit)               next_state = req_write_q ? IDLE : RESP;
        else if (victim_dirty) next_state = WB_REQ;
        else                   next_state = FILL_REQ;
      end
      WB_REQ:    if (mem_wr_req_ready) next_state = WB_DATA;
      WB_DATA:   if (mem_wr_data_ready && mem_wr_data_last) next_state = FILL_REQ;
      FILL_REQ:  if (mem_rd_req_ready) next_state = FILL_DATA;
      FILL_DATA: if (mem_rd_rsp_valid && mem_rd_rsp_last) next_state = LOOKUP; // now hits
      RESP:      if (rsp_ready) next_state = IDLE;
      default:   next_state = IDLE;
    endcase
  end

  // address fields of the held request
  assign index    = req_addr_q[`DC_OFFSET_W +: `DC_INDEX_W];
  assign tag      = req_addr_q[31 -: `DC_TAG_W];
  assign word_sel = req_addr_q[`DC_OFFSET_W-1:2];

  assign touch_en     = (state == LOOKUP) && hit;
  assign hit_wr_en    = touch_en && req_write_q;
  assign fill_beat_en = (state == FILL_DATA) && mem_rd_rsp_valid;
  assign fill_data    = mem_rd_rsp_data;
  assign wdata        = req_wdata_q;
  assign wstrb        = req_wstrb_q;

  assign rsp_valid = (state == RESP);
  assign rsp_data  = cur_line[word_sel * `DC_WORD_W +: `DC_WORD_W];

  assign mem_rd_req_valid = (state == FILL_REQ);
  assign mem_rd_req_addr  = {tag, index, {`DC_OFFSET_W{1'b0}}};  // line aligned
  assign mem_rd_rsp_ready = (state == FILL_DATA);

  assign mem_wr_req_valid  = (state == WB_REQ);
  assign mem_wr_req_addr   = {victim_tag, index, {`DC_OFFSET_W{1'b0}}};
  assign mem_wr_data_valid = (state == WB_DATA);
  assign mem_wr_data       = wb_line[`DC_WORD_W-1:0];
  assign mem_wr_data_last  = (wb_cnt == 3'(`DC_BEATS - 1));  // eighth beat of the write-back

  a_wr_last_valid: assert property (@(posedge clk) disable iff (rst)
    mem_wr_data_last |-> mem_wr_data_valid);

  a_ready_rsp_excl: assert property (@(posedge clk) disable iff (rst)
    !(req_ready && rsp_valid));

  // a finished refill must hit in exactly the way the lru picked
  a_fill_hits_victim: assert property (@(posedge clk) disable iff (rst)
    (state == LOOKUP && $past(state) == FILL_DATA) |-> (hit && hit_way == victim_way));

endmodule

`default_nettype wire

// ==== verilog/dcache_top.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "dcache_defs.svh"

module dcache_top
  import dcache_pkg::*;
(
  input  logic        clk,
  input  logic        rst,

  // cpu request
  input  logic        req_valid,
  input  logic        req_write,    // 1 write, 0 read
  input  logic [31:0] req_addr,
  input  logic [31:0] req_wdata,
  input  logic [3:0]  req_wstrb,
  output logic        req_ready,

  // cpu read response
  output logic        rsp_valid,
  output logic [31:0] rsp_data,
  input  logic        rsp_ready,

  // memory read burst
  output logic        mem_rd_req_valid,
  output logic [31:0] mem_rd_req_addr,
  input  logic        mem_rd_req_ready,
  input  logic        mem_rd_rsp_valid,
  input  logic [31:0] mem_rd_rsp_data,
  input  logic        mem_rd_rsp_last,
  output logic        mem_rd_rsp_ready,

  // memory write-back burst
  output logic        mem_wr_req_valid,
  output logic [31:0] mem_wr_req_addr,
  input  logic        mem_wr_req_ready,
  output logic        mem_wr_data_valid,
  output logic [31:0] mem_wr_data,
  output logic        mem_wr_data_last,
  input  logic        mem_wr_data_ready
);

  dc_index_t              index;        // set of the registered request
  dc_tag_t                tag;
  logic [2:0]             word_sel;     // word inside the line
  logic                   hit;
  dc_way_t                hit_way;
  dc_line_t               cur_line;     // hit line, else victim line
  dc_way_t                victim_way;   // lru choice at index
  logic                   victim_dirty;
  dc_tag_t                victim_tag;
  logic                   hit_wr_en;    // strobed merge into hit way
  logic                   fill_beat_en; // one refill word accepted
  logic [`DC_WORD_W-1:0]  fill_data;
  logic [`DC_WORD_W-1:0]  wdata;
  logic [3:0]             wstrb;
  logic                   touch_en;     // hit used, update lru

  dcache_ctrl u_ctrl (
    .clk               (clk),
    .rst               (rst),
    .req_valid         (req_valid),
    .req_write         (req_write),
    .req_addr          (req_addr),
    .req_wdata         (req_wdata),
    .req_wstrb         (req_wstrb),
    .req_ready         (req_ready),
    .rsp_valid         (rsp_valid),
    .rsp_data          (rsp_data),
    .rsp_ready         (rsp_ready),
    .mem_rd_req_valid  (mem_rd_req_valid),
    .mem_rd_req_addr   (mem_rd_req_addr),
    .mem_rd_req_ready  (mem_rd_req_ready),
    .mem_rd_rsp_valid  (mem_rd_rsp_valid),
    .mem_rd_rsp_data   (mem_rd_rsp_data),
    .mem_rd_rsp_last   (mem_rd_rsp_last),
    .mem_rd_rsp_ready  (mem_rd_rsp_ready),
    .mem_wr_req_valid  (mem_wr_req_valid),
    .mem_wr_req_addr   (mem_wr_req_addr),
    .mem_wr_req_ready  (mem_wr_req_ready),
    .mem_wr_data_valid (mem_wr_data_valid),
    .mem_wr_data       (mem_wr_data),
    .mem_wr_data_last  (mem_wr_data_last),
    .mem_wr_data_ready (mem_wr_data_ready),
    .hit               (hit),
    .hit_way           (hit_way),
    .cur_line          (cur_line),
    .victim_way        (victim_way),
    .victim_dirty      (victim_dirty),
    .victim_tag        (victim_tag),
    .index             (index),
    .tag               (tag),
    .word_sel          (word_sel),
    .hit_wr_en         (hit_wr_en),
    .fill_beat_en      (fill_beat_en),
    .fill_data         (fill_data),
    .wdata             (wdata),
    .wstrb             (wstrb),
    .touch_en          (touch_en)
  );

  dcache_line_store u_store (
    .clk          (clk),
    .rst          (rst),
    .index        (index),
    .tag          (tag),
    .word_sel     (word_sel),
    .wdata        (wdata),
    .wstrb        (wstrb),
    .hit_wr_en    (hit_wr_en),
    .fill_beat_en (fill_beat_en),
    .fill_data    (fill_data),
    .fill_way     (victim_way),  // refill always lands in the lru way
    .hit          (hit),
    .hit_way      (hit_way),
    .cur_line     (cur_line),
    .victim_dirty (victim_dirty),
    .victim_tag   (victim_tag)
  );

  lru_tracker u_lru (
    .clk        (clk),
    .rst        (rst),
    .index      (index),
    .touch_en   (touch_en),
    .hit_way    (hit_way),
    .victim_way (victim_way)
  );

endmodule

`default_nettype wire

// ==== dv/dcache_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module dcache_tb;

  localparam int MAX_CASES = 64;

  logic        clk;
  logic        rst = 1'b1;
  logic        req_valid = 1'b0;
  logic        req_write = 1'b0;
  logic [31:0] req_addr = '0;
  logic [31:0] req_wdata = '0;
  logic [3:0]  req_wstrb = '0;
  logic        req_ready;
  logic        rsp_valid;
  logic [31:0] rsp_data;
  logic        rsp_ready = 1'b0;
  logic        mem_rd_req_valid;
  logic [31:0] mem_rd_req_addr;
  logic        mem_rd_req_ready = 1'b0;
  logic        mem_rd_rsp_valid = 1'b0;
  logic [31:0] mem_rd_rsp_data = '0;
  logic        mem_rd_rsp_last = 1'b0;
  logic        mem_rd_rsp_ready;
  logic        mem_wr_req_valid;
  logic [31:0] mem_wr_req_addr;
  logic        mem_wr_req_ready = 1'b0;
  logic        mem_wr_data_valid;
  logic [31:0] mem_wr_data;
  logic        mem_wr_data_last;
  logic        mem_wr_data_ready = 1'b0;

  logic [31:0] case_mem [0:7*MAX_CASES-1];  // seven columns per case
  logic [31:0] mem [logic [31:0]];           // words written back, keyed by byte address
  logic [31:0] rnd_state = 32'h9f86;
  logic [31:0] fill_addr_exp = '0;           // line the current case may refill
  logic [31:0] rd_addr = '0;
  logic [31:0] wr_addr = '0;
  logic [3:0]  rd_beat = '0;
  logic [3:0]  wr_beat = '0;
  logic        rd_active = 1'b0;
  logic        wr_active = 1'b0;
  int          rd_bursts = 0;
  int          wr_bursts = 0;
  int          errors = 0;      // player side
  int          mem_errors = 0;  // memory model side
  int          num_cases = 0;
  int          cases_failed = 0;
  int          cycles = 0;
  int          timeout_cycles = 1000;

  dcache_top DUT (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // 8 ns period
  end

  function automatic logic [31:0] next_random(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // untouched memory holds its own address with a fixed pattern in the upper half
  function automatic logic [31:0] mem_word(input logic [31:0] a);
    if (mem.exists(a)) return mem[a];
    return a ^ 32'h5a5a0000;
  endfunction

  // memory model and every random stall live in one block, one draw per cycle
  always @(posedge clk) begin
    logic [31:0] r;
    r = next_random(rnd_state);
    rnd_state = r;
    if (rst) begin
      mem_rd_req_ready  <= 1'b0;
      mem_wr_req_ready  <= 1'b0;
      mem_wr_data_ready <= 1'b0;
      mem_rd_rsp_valid  <= 1'b0;
      mem_rd_rsp_last   <= 1'b0;
      rsp_ready         <= 1'b0;
    end else begin
      mem_rd_req_ready  <= (r[1:0] != 2'b00);  // ready about 3 cycles in 4
      mem_wr_req_ready  <= (r[3:2] != 2'b00);
      mem_wr_data_ready <= (r[5:4] != 2'b00);
      rsp_ready         <= (r[7:6] != 2'b00);
      if (mem_rd_req_valid && mem_rd_req_ready) begin
        if (mem_rd_req_addr != fill_addr_exp) begin
          $display("MISMATCH at %0t ns: mem_rd_req_addr expected %h got %h",
                   $time, fill_addr_exp, mem_rd_req_addr);
          mem_errors++;
        end
        rd_addr   = mem_rd_req_addr;
        rd_beat   = '0;
        rd_active = 1'b1;
        rd_bursts <= rd_bursts + 1;
      end
      if (mem_rd_rsp_valid && mem_rd_rsp_ready) begin
        rd_beat = rd_beat + 4'd1;
        if (mem_rd_rsp_last) rd_active = 1'b0;
      end
      if (rd_active && r[9:8] != 2'b00) begin  // gaps between refill beats too
        mem_rd_rsp_valid <= 1'b1;
        mem_rd_rsp_data  <= mem_word({rd_addr[31:5], rd_beat[2:0], 2'b00});
        mem_rd_rsp_last  <= (rd_beat == 4'd7);
      end else begin
        mem_rd_rsp_valid <= 1'b0;
        mem_rd_rsp_last  <= 1'b0;
      end
      if (mem_wr_req_valid && mem_wr_req_ready) begin
        if (wr_active || mem_wr_req_addr[4:0] != 5'd0) begin
          $display("write-back request at %0t ns is not line aligned or overlaps a burst",
                   $time);
          mem_errors++;
        end
        wr_addr   = mem_wr_req_addr;
        wr_beat   = '0;
        wr_active = 1'b1;
        wr_bursts <= wr_bursts + 1;
      end
      if (mem_wr_data_valid && mem_wr_data_ready) begin
        if (!wr_active) begin
          $display("write-back data at %0t ns arrived with no open burst", $time);
          mem_errors++;
        end else begin
          mem[{wr_addr[31:5], wr_beat[2:0], 2'b00}] = mem_wr_data;
          if (mem_wr_data_last != (wr_beat == 4'd7)) begin
            $display("MISMATCH at %0t ns: mem_wr_data_last expected %b got %b",
                     $time, (wr_beat == 4'd7), mem_wr_data_last);
            mem_errors++;
          end
          if (wr_beat == 4'd7) wr_active = 1'b0;  // burst is always eight beats
          wr_beat = wr_beat + 4'd1;
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > timeout_cycles) begin
      $display("timeout, the cases did not finish within %0d cycles", timeout_cycles);
      $display("tests failed");
      $finish;
    end
  end

  task automatic run_case(input int n);
    logic [31:0] op;
    logic [31:0] addr;
    logic [31:0] exp_data;
    int          exp_rd;
    int          exp_wb;
    int          rd_start;
    int          wb_start;
    int          err_start;
    int          lat;
    op        = case_mem[7*n];
    addr      = case_mem[7*n+1];
    exp_data  = case_mem[7*n+4];
    exp_rd    = int'(case_mem[7*n+5]);
    exp_wb    = int'(case_mem[7*n+6]);
    rd_start  = rd_bursts;
    wb_start  = wr_bursts;
    err_start = errors + mem_errors;
    lat       = 0;
    fill_addr_exp = {addr[31:5], 5'd0};
    @(posedge clk);
    req_valid <= 1'b1;
    req_write <= op[0];
    req_addr  <= addr;
    req_wdata <= case_mem[7*n+2];
    req_wstrb <= case_mem[7*n+3][3:0];
    do @(posedge clk); while (!req_ready);  // accepted on this edge
    req_valid <= 1'b0;
    if (op[0]) begin
      do begin
        @(posedge clk);
        lat++;
      end while (!req_ready);  // write done once the cache takes requests again
    end else begin
      do begin
        @(posedge clk);
        lat++;
      end while (!rsp_valid);
      while (!rsp_ready) begin
        @(posedge clk);
        if (!rsp_valid) begin
          $display("rsp_valid dropped at %0t ns before rsp_ready", $time);
          errors++;
        end
      end
      if (rsp_data !== exp_data) begin
        $display("MISMATCH at %0t ns: rsp_data expected %h got %h", $time, exp_data, rsp_data);
        errors++;
      end
    end
    if (exp_rd == 0 && lat != 2) begin  // hits answer in a fixed two cycles
      $display("hit at %0t ns took %0d cycles instead of 2", $time, lat);
      errors++;
    end
    if (rd_bursts - rd_start != exp_rd) begin
      $display("MISMATCH at %0t ns: read bursts expected %0d got %0d",
               $time, exp_rd, rd_bursts - rd_start);
      errors++;
    end
    if (wr_bursts - wb_start != exp_wb) begin
      $display("MISMATCH at %0t ns: write-back bursts expected %0d got %0d",
               $time, exp_wb, wr_bursts - wb_start);
      errors++;
    end
    if (errors + mem_errors != err_start) cases_failed++;
    $display("case %0d %s %h: %s", n, op[0] ? "write" : "read ", addr,
             (errors + mem_errors == err_start) ? "ok" : "FAILED");
  endtask

  initial begin
    for (int i = 0; i < 7*MAX_CASES; i++) case_mem[i] = '1;  // all ones marks the end
    $readmemh("dv/dcache_cases.txt", case_mem);
    while (num_cases < MAX_CASES && case_mem[7*num_cases] != 32'hffffffff) num_cases++;
    timeout_cycles = 300 * num_cases + 10;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    for (int n = 0; n < num_cases; n++) run_case(n);
    repeat (4) @(posedge clk);  // let any stray memory beat show up
    $display("%0d cases, %0d passed, %0d failed, %0d errors", num_cases,
             num_cases - cases_failed, cases_failed, errors + mem_errors);
    if (errors + mem_errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== dv/dcache_cases.txt ====
// op addr wdata wstrb exp_rdata rd_bursts wb_bursts
// op 0 read, 1 write; untouched memory word at byte address a holds a ^ 5a5a0000
0 00000024 00000000 0 5a5a0024 1 0 // cold miss, set 1
0 00000024 00000000 0 5a5a0024 0 0 // same word hits
0 0000003c 00000000 0 5a5a003c 0 0 // last word of the same line
1 00000024 a1b2c3d4 5 00000000 0 0 // write hit, bytes 0 and 2
0 00000024 00000000 0 5ab200d4 0 0 // only strobed bytes changed
0 00001048 00000000 0 5a5a1048 1 0 // A into set 2
1 00002044 11223344 f 00000000 1 0 // B write miss, allocated dirty
0 0000304c 00000000 0 5a5a304c 1 0 // C
0 00004050 00000000 0 5a5a4050 1 0 // D fills the set
0 00001040 00000000 0 5a5a1040 0 0 // touch A, B is now oldest
0 00005040 00000000 0 5a5a5040 1 1 // E evicts dirty B
0 00002044 00000000 0 11223344 1 0 // B back from memory, evicts C
0 00002048 00000000 0 5a5a2048 0 0
0 0000105c 00000000 0 5a5a105c 0 0 // A survived
0 00003040 00000000 0 5a5a3040 1 0 // C refetched, evicts D
0 00004054 00000000 0 5a5a4054 1 0 // D refetched, evicts E

// ==== flist.f ====
+incdir+common
common/dcache_pkg.sv
verilog/dcache_line_store.sv
verilog/lru_tracker.sv
verilog/dcache_ctrl.sv
verilog/dcache_top.sv
dv/dcache_tb.sv

// ==== Makefile ====
OBJ = obj_dir
LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f flist.f --top-module dcache_tb

sim:
	verilator --binary --timing --assert -f flist.f --top-module dcache_tb \
		-Mdir $(OBJ) -o dcache_tb
	./$(OBJ)/dcache_tb | tee $(LOG)
	grep -q "^all tests passed$$" $(LOG)

clean:
	rm -rf $(OBJ) $(LOG)
